/* design/gba_mem_pkg.sv */
`default_nettype none

package gba_mem_pkg;

    ////////////////////
    // region map

    localparam logic [3:0]  REGION_EWRAM   = 4'd2;    // 256KB, lives in sdram
    localparam logic [3:0]  REGION_PALETTE = 4'd5;    // bg + obj palettes
    localparam logic [3:0]  REGION_VRAM    = 4'd6;
    localparam logic [3:0]  REGION_OAM     = 4'd7;

    localparam logic [31:0] UNMAPPED_WORD      = 32'hdeadbeef;
    localparam logic [9:0]  SDRAM_CARTRAM_BASE = 10'b1000_0001_00;  // upper bits of 25:2
    localparam logic [7:0]  SDRAM_EWRAM_BASE   = 8'b1000_0000;

    typedef enum logic [1:0] {
        PORT_NONE,
        PORT_ROM,      // cpu instruction fetch
        PORT_RAM,      // cpu data access
        PORT_DMA
    } port_e;

    typedef enum logic [1:0] {
        ST_MAIN,       // idle, or a single-cycle access is on the video ports
        ST_START,      // sdram request goes out this cycle
        ST_WAIT        // waiting for sdram_ready
    } seq_state_e;

    ////////////////////
    // request types

    typedef struct packed {
        logic [3:0]  region;
        logic [23:0] offset;
    } gba_fields_t;

    typedef union packed {
        logic [27:0] raw;        // flat byte address
        gba_fields_t fields;
    } gba_addr_u;

    typedef struct packed {
        gba_addr_u   addr;
        logic [31:0] wdata;
        logic [3:0]  be;
        logic        wr;
        logic        rd;
    } mem_req_t;

    typedef struct packed {
        port_e       port;       // source that owns this sdram access
        logic [25:2] addr;       // word address
        logic [31:0] wdata;
        logic [3:0]  be;
        logic        rd;
        logic        wr;
    } sdram_req_t;

    ////////////////////
    // region helpers

    function automatic logic is_rom(input logic [3:0] region);
        return (region >= 4'h8) && (region <= 4'hc);    // game pak 8..C
    endfunction

    function automatic logic is_cartram(input logic [3:0] region);
        return region[3:1] == 3'b111;    // E and F mirror each other
    endfunction

    // everything not backed by sdram answers in one cycle, unmapped included
    function automatic logic is_single(input logic [3:0] region);
        return !(is_rom(region) || is_cartram(region) || region == REGION_EWRAM);
    endfunction

    function automatic logic is_readonly(input logic [3:0] region);
        return is_rom(region);
    endfunction

    function automatic logic [25:2] to_sdram_addr(input gba_addr_u a);
        logic [25:2] sa;
        sa = '1;                                                // unmapped
        if (is_rom(a.fields.region))
            sa = {1'b0, a.raw[24:2]};                           // 32MB rom
        else if (a.fields.region == REGION_EWRAM)
            sa = {SDRAM_EWRAM_BASE, a.raw[17:2]};
        else if (is_cartram(a.fields.region))
            sa = {SDRAM_CARTRAM_BASE, a.raw[15:2]};             // 64KB sram/flash
        return sa;
    endfunction

endpackage

`default_nettype wire

/* design/mem_sequencer.sv */
`default_nettype none

module mem_sequencer (
    input  wire                          clk,
    input  wire                          resetn,

    input  wire                          rom_en,
    input  wire gba_mem_pkg::gba_addr_u  rom_addr,
    input  wire                          ram_cen,
    input  wire gba_mem_pkg::mem_req_t   ram_req,
    output logic [31:0]                  rom_data,
    output logic [31:0]                  ram_rdata,
    output logic                         cpu_en,

    input  wire                          dma_on,
    input  wire                          dma_ena,
    input  wire gba_mem_pkg::mem_req_t   dma_req,
    output logic [31:0]                  dma_rdata,
    output logic                         dma_done,

    output gba_mem_pkg::mem_req_t        cur_req,
    output gba_mem_pkg::port_e           cur_port,
    output logic                         sdram_start,
    output gba_mem_pkg::mem_req_t        bram_req,
    input  wire [31:0]                   bram_rdata,
    input  wire [31:0]                   sdram_rdata,
    input  wire                          sdram_ready
);
    import gba_mem_pkg::*;

    seq_state_e  state;
    mem_req_t    sel_req;
    port_e       sel_port;
    logic        sel_single;
    logic        sel_bram;       // single-cycle access on the video ports now
    logic        done;           // current access completes this cycle
    port_e       last_port;      // read that completed last cycle
    logic        last_single;
    logic [31:0] rd_data;
    logic [31:0] rom_buf, ram_buf;

    ////////////////////
    // source priority

    always_comb begin
        sel_port = PORT_NONE;
        sel_req  = '0;
        if (dma_on) begin                   // dma owns the bus, cpu waits
            if (dma_ena) begin
                sel_port = PORT_DMA;
                sel_req  = dma_req;
            end
        end else if (rom_en) begin
            sel_port      = PORT_ROM;
            sel_req.addr  = rom_addr;
            sel_req.be    = 4'b1111;        // fetches are always full words
            sel_req.rd    = 1'b1;
        end else if (ram_cen) begin
            sel_port = PORT_RAM;
            sel_req  = ram_req;
        end
    end

    assign sel_single  = is_single(sel_req.addr.fields.region);
    assign sel_bram    = (state == ST_MAIN) && (sel_port != PORT_NONE) && sel_single;
    assign sdram_start = (state == ST_MAIN) && (sel_port != PORT_NONE) && !sel_single;
    assign done        = sel_bram || ((state == ST_WAIT) && sdram_ready);

    assign cur_req  = sel_req;
    assign cur_port = sel_port;

    always_comb begin
        bram_req = sel_req;
        if (!sel_bram) begin               // keep video memories quiet
            bram_req.rd = 1'b0;
            bram_req.wr = 1'b0;
        end
    end

    ////////////////////
    // ready / done strobes

    always_comb begin
        if (dma_on)
            cpu_en = 1'b0;                 // cpu paused during dma
        else if (!rom_en && !ram_cen)
            cpu_en = 1'b1;                 // nothing pending
        else
            cpu_en = done;
    end

    assign dma_done = dma_on && dma_ena && done;

    ////////////////////
    // state machine

    always_ff @(posedge clk) begin
        if (!resetn) begin
            state     <= ST_MAIN;
            last_port <= PORT_NONE;
            rom_buf   <= '0;
            ram_buf   <= '0;
        end else begin
            case (state)
                ST_MAIN:  if (sdram_start) state <= ST_START;
                ST_START: state <= ST_WAIT;      // request leaves sdram_request now
                ST_WAIT:  if (sdram_ready) state <= ST_MAIN;
                default:  state <= ST_MAIN;
            endcase
            last_port <= (done && sel_req.rd) ? sel_port : PORT_NONE;  // writes return nothing
            rom_buf   <= rom_data;        // buffers follow the outputs, so they hold
            ram_buf   <= ram_rdata;
        end
    end

    always_ff @(posedge clk)
        if (done)
            last_single <= (state == ST_MAIN);   // bram path vs sdram path

    ////////////////////
    // read data steering

    assign rd_data   = last_single ? bram_rdata : sdram_rdata;
    assign dma_rdata = rd_data;                  // valid the cycle after dma_done

    // dma reads never mark rom/ram, so the buffers survive preemption
    // and the first cycle after dma_on falls still shows them
    assign rom_data  = (last_port == PORT_ROM) ? rd_data : rom_buf;
    assign ram_rdata = (last_port == PORT_RAM) ? rd_data : ram_buf;

    // cpu presents one request at a time
    a_one_cpu_req: assert property (@(posedge clk) disable iff (!resetn)
        !(rom_en && ram_cen));

    // a wait only ends on the sdram's own ready, which never shows up outside a wait
    a_wait_exit: assert property (@(posedge clk) disable iff (!resetn)
        sdram_ready |-> state == ST_WAIT);

endmodule

`default_nettype wire

/* design/sdram_request.sv */
`default_nettype none

module sdram_request (
    input  wire                          clk,
    input  wire                          resetn,
    input  wire gba_mem_pkg::mem_req_t   cur_req,
    input  wire gba_mem_pkg::port_e      cur_port,
    input  wire                          sdram_start,
    output gba_mem_pkg::sdram_req_t      sdram_out
);
    import gba_mem_pkg::*;

    logic        rd_q, wr_q;     // one-cycle strobes
    port_e       port_q;
    logic [25:2] addr_q;
    logic [31:0] wdata_q;
    logic [3:0]  be_q;

    // control strobes
    always_ff @(posedge clk) begin
        if (!resetn) begin
            rd_q <= 1'b0;
            wr_q <= 1'b0;
        end else begin
            rd_q <= 1'b0;
            wr_q <= 1'b0;
            if (sdram_start) begin
                if (is_readonly(cur_req.addr.fields.region)) begin
                    rd_q <= 1'b1;                        // rom writes turn into reads
                end else begin
                    rd_q <= cur_req.rd;
                    wr_q <= cur_req.wr;
                end
            end
        end
    end

    // payload, captured with the start pulse
    always_ff @(posedge clk) begin
        if (sdram_start) begin
            port_q  <= cur_port;
            addr_q  <= to_sdram_addr(cur_req.addr);
            wdata_q <= cur_req.wdata;
            if (is_cartram(cur_req.addr.fields.region))
                be_q <= 4'b0001 << cur_req.addr.raw[1:0];   // cart ram is 8-bit wide
            else
                be_q <= cur_req.be;
        end
    end

    assign sdram_out = '{port: port_q, addr: addr_q, wdata: wdata_q,
                         be: be_q, rd: rd_q, wr: wr_q};

    a_rd_wr_excl: assert property (@(posedge clk) disable iff (!resetn)
        !(sdram_out.rd && sdram_out.wr));

endmodule

`default_nettype wire

/* design/video_mem_port.sv */
`default_nettype none

module video_mem_port (
    input  wire                          clk,
    input  wire gba_mem_pkg::mem_req_t   bram_req,
    output logic [31:0]                  bram_rdata,

    output logic [6:0]                   palette_bg_addr,
    output logic [31:0]                  palette_bg_din,
    output logic [3:0]                   palette_bg_we,
    input  wire  [31:0]                  palette_bg_dout,
    output logic [6:0]                   palette_oam_addr,
    output logic [31:0]                  palette_oam_din,
    output logic [3:0]                   palette_oam_we,
    input  wire  [31:0]                  palette_oam_dout,
    output logic [13:0]                  vram_lo_addr,
    output logic [31:0]                  vram_lo_din,
    output logic                         vram_lo_we,
    output logic [3:0]                   vram_lo_be,
    input  wire  [31:0]                  vram_lo_dout,
    output logic [12:0]                  vram_hi_addr,
    output logic [31:0]                  vram_hi_din,
    output logic                         vram_hi_we,
    output logic [3:0]                   vram_hi_be,
    input  wire  [31:0]                  vram_hi_dout,
    output logic [7:0]                   oamram_addr,
    output logic [31:0]                  oamram_din,
    output logic [3:0]                   oamram_we,
    input  wire  [31:0]                  oamram_dout
);
    import gba_mem_pkg::*;

    logic        sel_pal, sel_vram, sel_oam;
    logic        byte_wr;        // single-lane write
    logic [7:0]  wr_byte;
    logic [31:0] wdata16;
    logic [3:0]  be16;
    logic [3:0]  region_r;
    logic        a9_r, a16_r;

    assign sel_pal  = bram_req.addr.fields.region == REGION_PALETTE;
    assign sel_vram = bram_req.addr.fields.region == REGION_VRAM;
    assign sel_oam  = bram_req.addr.fields.region == REGION_OAM;

    ////////////////////
    // byte write widening

    always_comb begin
        case (bram_req.be)
            4'b0010: wr_byte = bram_req.wdata[15:8];
            4'b0100: wr_byte = bram_req.wdata[23:16];
            4'b1000: wr_byte = bram_req.wdata[31:24];
            default: wr_byte = bram_req.wdata[7:0];
        endcase
    end

    assign byte_wr = bram_req.wr && $onehot(bram_req.be);
    assign wdata16 = byte_wr ? {4{wr_byte}} : bram_req.wdata;   // byte lands in both halves
    assign be16    = !byte_wr ? bram_req.be :
                     (|bram_req.be[1:0]) ? 4'b0011 : 4'b1100;

    // palettes, bit 9 picks the object palette
    assign palette_bg_addr  = bram_req.addr.raw[8:2];
    assign palette_bg_din   = wdata16;
    assign palette_bg_we    = (bram_req.wr && sel_pal && !bram_req.addr.raw[9]) ? be16 : 4'b0;
    assign palette_oam_addr = bram_req.addr.raw[8:2];
    assign palette_oam_din  = wdata16;
    assign palette_oam_we   = (bram_req.wr && sel_pal && bram_req.addr.raw[9]) ? be16 : 4'b0;

    // vram, bit 16 picks the upper 32KB
    assign vram_lo_addr = bram_req.addr.raw[15:2];
    assign vram_lo_din  = wdata16;
    assign vram_lo_we   = bram_req.wr && sel_vram && !bram_req.addr.raw[16];
    assign vram_lo_be   = bram_req.wr ? be16 : 4'b1111;
    assign vram_hi_addr = bram_req.addr.raw[14:2];
    assign vram_hi_din  = bram_req.wdata;
    assign vram_hi_we   = bram_req.wr && sel_vram && bram_req.addr.raw[16] && !byte_wr;
    assign vram_hi_be   = bram_req.wr ? bram_req.be : 4'b1111;

    // oam drops byte writes
    assign oamram_addr = bram_req.addr.raw[9:2];
    assign oamram_din  = bram_req.wdata;
    assign oamram_we   = (bram_req.wr && sel_oam && !byte_wr) ? bram_req.be : 4'b0;

    ////////////////////
    // read mux, one cycle behind

    always_ff @(posedge clk) begin
        if (bram_req.rd) begin
            region_r <= bram_req.addr.fields.region;
            a9_r     <= bram_req.addr.raw[9];
            a16_r    <= bram_req.addr.raw[16];
        end
    end

    always_comb begin
        case (region_r)
            REGION_PALETTE: bram_rdata = a9_r ? palette_oam_dout : palette_bg_dout;
            REGION_VRAM:    bram_rdata = a16_r ? vram_hi_dout : vram_lo_dout;
            REGION_OAM:     bram_rdata = oamram_dout;
            default:        bram_rdata = UNMAPPED_WORD;     // 0, 3, 4, D and friends
        endcase
    end

endmodule

`default_nettype wire

/* design/gba_memory.sv */
`default_nettype none

module gba_memory (
    input  wire                          clk,
    input  wire                          resetn,

    // cpu side
    input  wire                          rom_en,
    input  wire gba_mem_pkg::gba_addr_u  rom_addr,
    input  wire                          ram_cen,
    input  wire gba_mem_pkg::mem_req_t   ram_req,
    output wire [31:0]                   rom_data,
    output wire [31:0]                   ram_rdata,
    output wire                          cpu_en,      // data shows up next cycle

    // dma side
    input  wire                          dma_on,
    input  wire                          dma_ena,
    input  wire gba_mem_pkg::mem_req_t   dma_req,
    output wire [31:0]                   dma_rdata,
    output wire                          dma_done,

    // sdram
    output wire gba_mem_pkg::sdram_req_t sdram_out,
    input  wire [31:0]                   sdram_rdata,
    input  wire                          sdram_ready,

    // video memories
    output wire [6:0]                    palette_bg_addr,
    output wire [31:0]                   palette_bg_din,
    output wire [3:0]                    palette_bg_we,
    input  wire [31:0]                   palette_bg_dout,
    output wire [6:0]                    palette_oam_addr,
    output wire [31:0]                   palette_oam_din,
    output wire [3:0]                    palette_oam_we,
    input  wire [31:0]                   palette_oam_dout,
    output wire [13:0]                   vram_lo_addr,
    output wire [31:0]                   vram_lo_din,
    output wire                          vram_lo_we,
    output wire [3:0]                    vram_lo_be,
    input  wire [31:0]                   vram_lo_dout,
    output wire [12:0]                   vram_hi_addr,
    output wire [31:0]                   vram_hi_din,
    output wire                          vram_hi_we,
    output wire [3:0]                    vram_hi_be,
    input  wire [31:0]                   vram_hi_dout,
    output wire [7:0]                    oamram_addr,
    output wire [31:0]                   oamram_din,
    output wire [3:0]                    oamram_we,
    input  wire [31:0]                   oamram_dout
);
    import gba_mem_pkg::*;

    mem_req_t    cur_req;       // chosen source, to sdram side
    port_e       cur_port;
    wire         sdram_start;
    mem_req_t    bram_req;      // single-cycle request, rd/wr gated
    wire [31:0]  bram_rdata;

    mem_sequencer seq_i (.*);

    sdram_request sdram_req_i (
        .clk, .resetn, .cur_req, .cur_port, .sdram_start, .sdram_out
    );

    video_mem_port video_i (.*);

endmodule

`default_nettype wire

/* tests/mem_models.sv */
`default_nettype none

// sdram behind the mux, word wide, random latency per access
module sdram_model #(
    parameter int MAX_LAT = 6
) (
    input  wire                          clk,
    input  wire                          resetn,
    input  wire gba_mem_pkg::sdram_req_t req,
    output logic [31:0]                  rdata,
    output logic                         ready,
    input  wire [23:0]                   peek_addr,    // backdoor for the testbench
    output logic [31:0]                  peek_data
);
    import gba_mem_pkg::*;

    logic [31:0] mem [logic [23:0]];    // sparse, untouched words read the fill
    logic [31:0] wr_word;
    logic [23:0] addr_q;
    logic        busy;
    int unsigned wait_cnt;

    function automatic logic [31:0] read_word(input logic [23:0] a);
        if (mem.exists(a))
            return mem[a];
        return {a[7:0] ^ 8'h3c, a};     // fill follows every address bit
    endfunction

    assign peek_data = read_word(peek_addr);

    always @(posedge clk) begin
        ready <= 1'b0;
        if (!resetn) begin
            busy  <= 1'b0;
            rdata <= '0;
        end else if (req.rd || req.wr) begin
            busy     <= 1'b1;
            addr_q   <= req.addr;
            wait_cnt <= $urandom_range(MAX_LAT, 0);
            if (req.wr) begin
                wr_word = read_word(req.addr);
                for (int i = 0; i < 4; i++)
                    if (req.be[i])
                        wr_word[8*i +: 8] = req.wdata[8*i +: 8];    // byte lanes
                mem[req.addr] = wr_word;
            end
        end else if (busy) begin
            if (wait_cnt == 0) begin
                ready <= 1'b1;
                rdata <= read_word(addr_q);     // held until the next request
                busy  <= 1'b0;
            end else begin
                wait_cnt <= wait_cnt - 1;
            end
        end
    end

endmodule

// palette, vram or oam block with byte lane writes and registered dout
module video_ram_model #(
    parameter int         AW   = 7,
    parameter logic [7:0] FILL = 8'h00
) (
    input  wire          clk,
    input  wire [AW-1:0] addr,
    input  wire [31:0]   din,
    input  wire [3:0]    we,      // one bit per byte lane
    output logic [31:0]  dout
);
    logic [31:0] mem [2**AW];

    initial
        for (int i = 0; i < 2**AW; i++)
            mem[i] = {FILL, 24'(i)};

    always @(posedge clk) begin
        for (int i = 0; i < 4; i++)
            if (we[i])
                mem[addr][8*i +: 8] <= din[8*i +: 8];
        dout <= mem[addr];            // old word on a write cycle
    end

endmodule

`default_nettype wire

/* tests/gba_memory_tb.sv */
`default_nettype none

module gba_memory_tb;
    import gba_mem_pkg::*;

    localparam int          TIMEOUT_CYCLES = 4000;   // ~35 accesses of under 20 cycles each
    localparam int          SDRAM_MAX_LAT  = 6;
    localparam logic [31:0] RAND_SEED      = 32'h10482c9f;
    localparam logic [27:0] VIDEO_ADDRS [5] = '{28'h5000010, 28'h5000210, 28'h6000100,
                                                28'h6010100, 28'h7000040};

    logic        clk, resetn;
    logic        rom_en, ram_cen, dma_on, dma_ena;
    gba_addr_u   rom_addr;
    mem_req_t    ram_req, dma_req;
    wire  [31:0] rom_data, ram_rdata, dma_rdata;
    wire         cpu_en, dma_done;
    sdram_req_t  sdram_out;
    sdram_req_t  last_cmd;       // latest rd/wr pulse seen on sdram_out
    wire  [31:0] sdram_rdata;
    wire         sdram_ready;
    logic [23:0] peek_addr;
    wire  [31:0] peek_data;

    wire  [6:0]  palette_bg_addr, palette_oam_addr;
    wire  [31:0] palette_bg_din, palette_oam_din, palette_bg_dout, palette_oam_dout;
    wire  [3:0]  palette_bg_we, palette_oam_we, vram_lo_be, vram_hi_be, oamram_we;
    wire  [13:0] vram_lo_addr;
    wire  [12:0] vram_hi_addr;
    wire  [7:0]  oamram_addr;
    wire  [31:0] vram_lo_din, vram_hi_din, oamram_din, vram_lo_dout, vram_hi_dout, oamram_dout;
    wire         vram_lo_we, vram_hi_we;

    string       test_name;
    int          n_errors, n_tests;
    int unsigned cycles = 0;

    gba_memory gba_memory_i (.*);

    sdram_model #(.MAX_LAT(SDRAM_MAX_LAT)) sdram_i (
        .clk, .resetn, .req(sdram_out), .rdata(sdram_rdata), .ready(sdram_ready),
        .peek_addr, .peek_data
    );
    video_ram_model #(.AW(7), .FILL(8'h51)) pal_bg_i (.clk, .addr(palette_bg_addr),
        .din(palette_bg_din), .we(palette_bg_we), .dout(palette_bg_dout));
    video_ram_model #(.AW(7), .FILL(8'h52)) pal_obj_i (.clk, .addr(palette_oam_addr),
        .din(palette_oam_din), .we(palette_oam_we), .dout(palette_oam_dout));
    video_ram_model #(.AW(14), .FILL(8'h61)) vram_lo_i (.clk, .addr(vram_lo_addr),
        .din(vram_lo_din), .we({4{vram_lo_we}} & vram_lo_be), .dout(vram_lo_dout));
    video_ram_model #(.AW(13), .FILL(8'h62)) vram_hi_i (.clk, .addr(vram_hi_addr),
        .din(vram_hi_din), .we({4{vram_hi_we}} & vram_hi_be), .dout(vram_hi_dout));
    video_ram_model #(.AW(8), .FILL(8'h70)) oam_i (.clk, .addr(oamram_addr),
        .din(oamram_din), .we(oamram_we), .dout(oamram_dout));

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk)
        if (sdram_out.rd || sdram_out.wr)
            last_cmd <= sdram_out;

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles == TIMEOUT_CYCLES) begin
            $display("timeout: run still busy after %0d cycles", TIMEOUT_CYCLES);
            $display("CHECKS FAILED");
            $finish;
        end
    end

    ////////////////////
    // helpers

    task automatic report_mismatch(input string what, input logic [31:0] exp,
                                   input logic [31:0] act);
        $display("ERR %s %s: expected %h, actual %h", test_name, what, exp, act);
        n_errors++;
    endtask

    task automatic report_problem(input string msg);
        $display("%s: %s", test_name, msg);
        n_errors++;
    endtask

    function automatic mem_req_t make_req(input logic [27:0] addr, input logic [31:0] wdata,
                                          input logic [3:0] be, input logic wr);
        mem_req_t r;
        r.addr.raw = addr;
        r.wdata    = wdata;
        r.be       = be;
        r.wr       = wr;
        r.rd       = !wr;
        return r;
    endfunction

    task automatic peek_word(input logic [23:0] a, output logic [31:0] d);
        peek_addr = a;
        #1;                      // let the model's read settle
        d = peek_data;
    endtask

    // request held until cpu_en, data sampled one cycle later
    task automatic cpu_access(input logic fetch, input mem_req_t req, output logic [31:0] data);
        @(posedge clk);
        if (fetch) begin
            rom_en   <= 1'b1;
            rom_addr <= req.addr;
        end else begin
            ram_cen <= 1'b1;
            ram_req <= req;
        end
        @(negedge clk);
        while (!cpu_en)
            @(negedge clk);
        @(posedge clk);
        rom_en  <= 1'b0;
        ram_cen <= 1'b0;
        @(negedge clk);
        data = fetch ? rom_data : ram_rdata;
    endtask

    task automatic cpu_read(input logic fetch, input logic [27:0] a, output logic [31:0] d);
        cpu_access(fetch, make_req(a, '0, 4'hf, 1'b0), d);
    endtask

    task automatic cpu_write(input logic [27:0] a, input logic [31:0] wdata, input logic [3:0] be);
        logic [31:0] discard;
        cpu_access(1'b0, make_req(a, wdata, be, 1'b1), discard);
    endtask

    // one dma access while dma_on is up, cpu side must stay frozen
    task automatic dma_access(input mem_req_t req, input logic [31:0] held,
                              output logic [31:0] data);
        @(posedge clk);
        dma_ena <= 1'b1;
        dma_req <= req;
        @(negedge clk);
        while (!dma_done) begin
            if (cpu_en)
                report_problem("cpu_en high while dma_on is set");
            if (rom_data !== held)
                report_mismatch("rom_data during dma", held, rom_data);
            @(negedge clk);
        end
        if (cpu_en)
            report_problem("cpu_en high in the dma_done cycle");
        @(posedge clk);
        dma_ena <= 1'b0;
        @(negedge clk);
        if (dma_done)
            report_problem("dma_done longer than one cycle");
        if (rom_data !== held)
            report_mismatch("rom_data after dma access", held, rom_data);
        data = dma_rdata;
    endtask

    ////////////////////
    // directed tests

    task automatic idle_after_reset();
        test_name = "idle_after_reset";
        n_tests++;
        @(negedge clk);
        if (sdram_out.rd || sdram_out.wr)
            report_problem("sdram strobe active with no request");
        if (|{palette_bg_we, palette_oam_we, vram_lo_we, vram_hi_we, oamram_we})
            report_problem("video write enable active with no request");
        if (!cpu_en)
            report_problem("cpu_en low with no request");
    endtask

    task automatic video_rw();
        logic [31:0] wdata, rdata, old;
        logic [7:0]  b;
        test_name = "video_rw";
        n_tests++;
        for (int i = 0; i < 5; i++) begin
            wdata = $urandom;
            cpu_write(VIDEO_ADDRS[i], wdata, 4'hf);
            cpu_read(1'b0, VIDEO_ADDRS[i], rdata);
            if (rdata !== wdata)
                report_mismatch("word readback", wdata, rdata);
        end
        b = 8'($urandom);
        cpu_read(1'b0, 28'h5000020, old);
        cpu_write(28'h5000021, {~b, ~b, b, ~b}, 4'b0010);   // lane 1 fills the low halfword
        cpu_read(1'b0, 28'h5000020, rdata);
        if (rdata !== {old[31:16], b, b})
            report_mismatch("palette byte", {old[31:16], b, b}, rdata);
        cpu_read(1'b0, 28'h7000080, old);
        cpu_write(28'h7000082, {4{b}}, 4'b0100);
        cpu_read(1'b0, 28'h7000080, rdata);
        if (rdata !== old)
            report_mismatch("oam byte ignored", old, rdata);
        cpu_read(1'b0, 28'h3000400, rdata);
        if (rdata !== UNMAPPED_WORD)
            report_mismatch("region 3 read", UNMAPPED_WORD, rdata);
    endtask

    task automatic rom_fetch();
        logic [27:0] a;
        logic [23:0] sa;
        logic [31:0] rdata, exp;
        test_name = "rom_fetch";
        n_tests++;
        for (int i = 0; i < 2; i++) begin
            a  = (i == 0) ? 28'h8001234 : 28'ha0abcd0;
            sa = {1'b0, a[24:2]};                   // rom maps straight onto word address
            cpu_read(1'b1, a, rdata);
            peek_word(sa, exp);
            if (last_cmd.addr !== sa)
                report_mismatch("sdram addr", {8'h0, sa}, {8'h0, last_cmd.addr});
            if (!last_cmd.rd || last_cmd.wr || last_cmd.be !== 4'hf)
                report_problem("fetch not sent as a full word read");
            if (last_cmd.port !== PORT_ROM)
                report_mismatch("sdram port", {30'h0, PORT_ROM}, {30'h0, last_cmd.port});
            if (rdata !== exp)
                report_mismatch("rom_data", exp, rdata);
        end
    endtask

    task automatic sdram_writes();
        logic [27:0] a;
        logic [23:0] sa;
        logic [31:0] wdata, old, exp, rdata;
        test_name = "sdram_writes";
        n_tests++;
        a     = 28'h2001238;
        sa    = {SDRAM_EWRAM_BASE, a[17:2]};
        wdata = $urandom;
        peek_word(sa, old);
        cpu_write(a, wdata, 4'b0110);                // middle lanes only
        if (last_cmd.addr !== sa)
            report_mismatch("ewram addr", {8'h0, sa}, {8'h0, last_cmd.addr});
        if (!last_cmd.wr || last_cmd.wdata !== wdata || last_cmd.be !== 4'b0110)
            report_problem("ewram write reached the sdram with wrong data or byte enables");
        if (last_cmd.port !== PORT_RAM)
            report_mismatch("ewram port", {30'h0, PORT_RAM}, {30'h0, last_cmd.port});
        exp = {old[31:24], wdata[23:8], old[7:0]};
        peek_word(sa, rdata);
        if (rdata !== exp)
            report_mismatch("ewram word", exp, rdata);
        cpu_read(1'b0, a, rdata);
        if (rdata !== exp)
            report_mismatch("ewram readback", exp, rdata);
        a  = 28'he000123;
        sa = {SDRAM_CARTRAM_BASE, a[15:2]};
        cpu_write(a, {4{wdata[7:0]}}, 4'b1111);     // lane comes from the address
        if (last_cmd.addr !== sa)
            report_mismatch("cart ram addr", {8'h0, sa}, {8'h0, last_cmd.addr});
        if (last_cmd.be !== 4'b1000)
            report_mismatch("cart ram be", 32'h8, {28'h0, last_cmd.be});
        a  = 28'h8000100;
        sa = {1'b0, a[24:2]};
        peek_word(sa, old);
        cpu_write(a, ~old, 4'hf);
        if (!last_cmd.rd || last_cmd.wr)
            report_problem("rom write was not sent as a read");
        peek_word(sa, rdata);
        if (rdata !== old)
            report_mismatch("rom unchanged", old, rdata);
    endtask

    task automatic dma_preemption();
        logic [27:0] a;
        logic [31:0] held, exp, wdata, rdata;
        test_name = "dma_preemption";
        n_tests++;
        a = 28'h8002000;
        peek_word({1'b0, a[24:2]}, held);
        cpu_read(1'b1, a, rdata);
        if (rdata !== held)
            report_mismatch("cpu rom read", held, rdata);
        @(posedge clk);
        dma_on <= 1'b1;
        @(negedge clk);
        if (cpu_en)
            report_problem("cpu_en high once dma_on rose");
        a = 28'h9004440;
        peek_word({1'b0, a[24:2]}, exp);
        dma_access(make_req(a, '0, 4'hf, 1'b0), held, rdata);
        if (last_cmd.port !== PORT_DMA)
            report_mismatch("dma sdram port", {30'h0, PORT_DMA}, {30'h0, last_cmd.port});
        if (rdata !== exp)
            report_mismatch("dma sdram read", exp, rdata);
        wdata = $urandom;
        dma_access(make_req(28'h6000200, wdata, 4'hf, 1'b1), held, rdata);
        @(posedge clk);
        dma_on <= 1'b0;
        @(negedge clk);
        if (rom_data !== held)
            report_mismatch("rom_data after dma_on fell", held, rom_data);
        cpu_read(1'b0, 28'h6000200, rdata);
        if (rdata !== wdata)
            report_mismatch("dma video write", wdata, rdata);
    endtask

    initial begin
        void'($urandom(RAND_SEED));
        n_errors  = 0;
        n_tests   = 0;
        resetn    = 1'b0;
        rom_en    = 1'b0;
        rom_addr  = '0;
        ram_cen   = 1'b0;
        ram_req   = '0;
        dma_on    = 1'b0;
        dma_ena   = 1'b0;
        dma_req   = '0;
        peek_addr = '0;
        repeat (3) @(posedge clk);
        resetn <= 1'b1;
        idle_after_reset();
        video_rw();
        rom_fetch();
        sdram_writes();
        dma_preemption();
        $display("tests run: %0d, errors: %0d", n_tests, n_errors);
        if (n_errors == 0)
            $display("ALL CHECKS PASSED");
        else
            $display("CHECKS FAILED");
        $finish;
    end

endmodule

`default_nettype wire

/* gba_memory.f */
design/gba_mem_pkg.sv
design/mem_sequencer.sv
design/sdram_request.sv
design/video_mem_port.sv
design/gba_memory.sv
tests/mem_models.sv
tests/gba_memory_tb.sv

/* run_sim.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f gba_memory.f \
    --top-module gba_memory_tb --Mdir obj_dir -o gba_memory_sim

./obj_dir/gba_memory_sim > sim.log
cat sim.log

if grep -q "CHECKS FAILED" sim.log; then
    exit 1
fi
